// ==== icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        16
`define ICACHE_LINE_WORDS  16

`define ICACHE_TAG_W       22
`define ICACHE_INDEX_W     4
`define ICACHE_OFFSET_W    4
`define ICACHE_AGE_W       2

// Byte address split, bits 1:0 ignored
`define ICACHE_TAG_MSB     31
`define ICACHE_TAG_LSB     10
`define ICACHE_INDEX_MSB   9
`define ICACHE_INDEX_LSB   6
`define ICACHE_OFFSET_MSB  5
`define ICACHE_OFFSET_LSB  2

`endif

// ==== icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

  typedef logic [31:0]                       addr_t;
  typedef logic [31:0]                       word_t;
  typedef logic [`ICACHE_TAG_W-1:0]          tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]        index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0]       offset_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0]   way_t;
  // 0 is the most recently used way
  typedef logic [`ICACHE_AGE_W-1:0]          age_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_REFILL_WAIT,
    CTRL_REPLAY
  } ctrl_state_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_REQUEST,
    REFILL_DATA,
    REFILL_COMMIT
  } refill_state_t;

endpackage

// ==== icache_tag_store.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_store (
  input  logic                                    clk,
  input  logic                                    rst,
  input  icache_pkg::index_t                      rd_index,
  input  logic                                    wr_en,
  input  icache_pkg::index_t                      wr_index,
  input  icache_pkg::way_t                        wr_way,
  input  icache_pkg::tag_t                        wr_tag,
  input  logic                                    touch,
  input  icache_pkg::way_t                        touch_way,
  output icache_pkg::tag_t [`ICACHE_WAYS-1:0]     tags,
  output logic [`ICACHE_WAYS-1:0]                 valids,
  output icache_pkg::age_t [`ICACHE_WAYS-1:0]     ages
);

  icache_pkg::tag_t                      tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0]               valid_r [`ICACHE_SETS];
  icache_pkg::age_t [`ICACHE_WAYS-1:0]   age_r   [`ICACHE_SETS];
  icache_pkg::index_t                    set_q;

  // Registered read set, one cycle of read latency
  always_ff @(posedge clk)
  begin
    set_q <= rd_index;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      tag_mem[wr_way][wr_index] <= wr_tag;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid bits and LRU ages
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        valid_r[s] <= '0;
        age_r[s]   <= '0;
      end
    end
    else
    begin
      if (wr_en)
        valid_r[wr_index][wr_way] <= 1'b1;
      // Ages at or below the touched age move up one, touched way goes to 0
      if (touch)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
          if (icache_pkg::way_t'(w) == touch_way)
            age_r[set_q][w] <= '0;
          else if (ages[w] <= ages[touch_way])
            age_r[set_q][w] <= ages[w] + 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      tags[w] = tag_mem[w][set_q];
    valids = valid_r[set_q];
    ages   = age_r[set_q];
  end

endmodule

// ==== icache_hit_select.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_hit_select (
  input  icache_pkg::tag_t                        lookup_tag,
  input  icache_pkg::tag_t [`ICACHE_WAYS-1:0]     tags,
  input  logic [`ICACHE_WAYS-1:0]                 valids,
  input  icache_pkg::age_t [`ICACHE_WAYS-1:0]     ages,
  output logic                                    hit,
  output icache_pkg::way_t                        hit_way,
  output icache_pkg::way_t                        victim_way
);

  icache_pkg::way_t oldest_way;
  icache_pkg::age_t oldest_age;

  // Walk downwards so the lowest matching way wins
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = `ICACHE_WAYS-1; w >= 0; w--)
    begin
      if (valids[w] && tags[w] == lookup_tag)
      begin
        hit     = 1'b1;
        hit_way = icache_pkg::way_t'(w);
      end
    end
  end

  // First invalid way, else the oldest one
  always_comb
  begin
    oldest_way = '0;
    oldest_age = ages[0];
    for (int w = 1; w < `ICACHE_WAYS; w++)
    begin
      if (ages[w] > oldest_age)
      begin
        oldest_age = ages[w];
        oldest_way = icache_pkg::way_t'(w);
      end
    end
    victim_way = oldest_way;
    for (int w = `ICACHE_WAYS-1; w >= 0; w--)
      if (!valids[w])
        victim_way = icache_pkg::way_t'(w);
  end

endmodule

// ==== icache_data_store.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_store (
  input  logic                 clk,
  input  icache_pkg::index_t   rd_index,
  input  icache_pkg::offset_t  rd_offset,
  input  icache_pkg::way_t     sel_way,
  input  logic                 wr_en,
  input  icache_pkg::way_t     wr_way,
  input  icache_pkg::index_t   wr_index,
  input  icache_pkg::offset_t  wr_offset,
  input  icache_pkg::word_t    wr_data,
  output icache_pkg::word_t    rd_word
);

  localparam int DEPTH = `ICACHE_SETS * `ICACHE_LINE_WORDS;

  icache_pkg::word_t mem  [`ICACHE_WAYS][DEPTH];
  icache_pkg::word_t rd_q [`ICACHE_WAYS];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_way][{wr_index, wr_offset}] <= wr_data;
  end

  // All ways read in parallel, way picked after the edge
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      rd_q[w] <= mem[w][{rd_index, rd_offset}];
  end

  assign rd_word = rd_q[sel_way];

endmodule

// ==== icache_refill.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_refill (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  icache_pkg::addr_t    line_addr,
  input  icache_pkg::way_t     way,
  input  logic                 mem_addr_ok,
  input  logic                 mem_data_ok,
  input  icache_pkg::word_t    mem_data,
  output logic                 mem_req,
  output icache_pkg::addr_t    mem_addr,
  output logic                 data_wr_en,
  output icache_pkg::offset_t  data_wr_offset,
  output icache_pkg::word_t    data_wr_data,
  output logic                 tag_wr_en,
  output icache_pkg::way_t     wr_way,
  output logic                 done
);

  localparam icache_pkg::offset_t LAST_BEAT = icache_pkg::offset_t'(`ICACHE_LINE_WORDS - 1);

  icache_pkg::refill_state_t state;
  icache_pkg::offset_t       beat;
  icache_pkg::addr_t         line_q;
  icache_pkg::way_t          way_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= icache_pkg::REFILL_IDLE;
      beat  <= '0;
    end
    else
    begin
      case (state)
        icache_pkg::REFILL_IDLE:
          if (start)
            state <= icache_pkg::REFILL_REQUEST;
        // Hold the request until memory takes the address
        icache_pkg::REFILL_REQUEST:
          if (mem_addr_ok)
            state <= icache_pkg::REFILL_DATA;
        icache_pkg::REFILL_DATA:
          if (mem_data_ok)
          begin
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT)
              state <= icache_pkg::REFILL_COMMIT;
          end
        default:
          state <= icache_pkg::REFILL_IDLE;
      endcase
    end
  end

  // Line base and victim way stay put for the whole refill
  always_ff @(posedge clk)
  begin
    if (state == icache_pkg::REFILL_IDLE && start)
    begin
      line_q <= line_addr;
      way_q  <= way;
    end
  end

  assign mem_req        = (state == icache_pkg::REFILL_REQUEST);
  assign mem_addr       = line_q;
  assign data_wr_en     = (state == icache_pkg::REFILL_DATA) && mem_data_ok;
  assign data_wr_offset = beat;
  assign data_wr_data   = mem_data;
  assign tag_wr_en      = (state == icache_pkg::REFILL_COMMIT);
  assign wr_way         = way_q;
  assign done           = (state == icache_pkg::REFILL_COMMIT);

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  icache_pkg::addr_t    fetch_addr,
  input  logic                 hit,
  input  icache_pkg::way_t     hit_way,
  input  icache_pkg::way_t     victim_way,
  input  logic                 done,
  output logic                 ok,
  output icache_pkg::index_t   rd_index,
  output icache_pkg::offset_t  rd_offset,
  output icache_pkg::tag_t     lookup_tag,
  output icache_pkg::way_t     sel_way,
  output logic                 refill_start,
  output icache_pkg::addr_t    refill_addr,
  output icache_pkg::way_t     refill_way,
  output logic                 touch,
  output icache_pkg::way_t     touch_way
);

  icache_pkg::ctrl_state_t state;
  icache_pkg::addr_t       addr_q;
  icache_pkg::addr_t       rd_addr;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= icache_pkg::CTRL_IDLE;
    else
    begin
      case (state)
        icache_pkg::CTRL_IDLE:
          if (req)
            state <= icache_pkg::CTRL_LOOKUP;
        icache_pkg::CTRL_LOOKUP:
          if (hit)
            state <= icache_pkg::CTRL_IDLE;
          else
            state <= icache_pkg::CTRL_REFILL_WAIT;
        icache_pkg::CTRL_REFILL_WAIT:
          if (done)
            state <= icache_pkg::CTRL_REPLAY;
        default:
          state <= icache_pkg::CTRL_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == icache_pkg::CTRL_IDLE && req)
      addr_q <= fetch_addr;
  end

  // Stores read straight from the CPU in IDLE, from the held address otherwise
  assign rd_addr    = (state == icache_pkg::CTRL_IDLE) ? fetch_addr : addr_q;
  assign rd_index   = rd_addr[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB];
  assign rd_offset  = rd_addr[`ICACHE_OFFSET_MSB:`ICACHE_OFFSET_LSB];
  assign lookup_tag = addr_q[`ICACHE_TAG_MSB:`ICACHE_TAG_LSB];
  assign sel_way    = hit_way;

  assign ok        = (state == icache_pkg::CTRL_LOOKUP) && hit;
  assign touch     = ok;
  assign touch_way = hit_way;

  assign refill_start = (state == icache_pkg::CTRL_LOOKUP) && !hit;
  assign refill_addr  = {addr_q[`ICACHE_TAG_MSB:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};
  assign refill_way   = victim_way;

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  icache_pkg::addr_t  fetch_addr,
  output icache_pkg::word_t  inst,
  output logic               ok,
  output logic               mem_req,
  output icache_pkg::addr_t  mem_addr,
  input  logic               mem_addr_ok,
  input  logic               mem_data_ok,
  input  icache_pkg::word_t  mem_data
);

  icache_pkg::index_t                    rd_index;
  icache_pkg::offset_t                   rd_offset;
  icache_pkg::tag_t                      lookup_tag;
  icache_pkg::way_t                      sel_way;
  icache_pkg::tag_t [`ICACHE_WAYS-1:0]   tags;
  logic [`ICACHE_WAYS-1:0]               valids;
  icache_pkg::age_t [`ICACHE_WAYS-1:0]   ages;
  logic                                  hit;
  icache_pkg::way_t                      hit_way;
  icache_pkg::way_t                      victim_way;
  logic                                  refill_start;
  icache_pkg::addr_t                     refill_addr;
  icache_pkg::way_t                      refill_way;
  logic                                  touch;
  icache_pkg::way_t                      touch_way;
  logic                                  data_wr_en;
  icache_pkg::offset_t                   data_wr_offset;
  icache_pkg::word_t                     data_wr_data;
  logic                                  tag_wr_en;
  icache_pkg::way_t                      wr_way;
  logic                                  done;

  ////////////////////////////////////////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////////////////////////////////////////

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .fetch_addr   (fetch_addr),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .done         (done),
    .ok           (ok),
    .rd_index     (rd_index),
    .rd_offset    (rd_offset),
    .lookup_tag   (lookup_tag),
    .sel_way      (sel_way),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .refill_way   (refill_way),
    .touch        (touch),
    .touch_way    (touch_way)
  );

  icache_hit_select u_hit_select (
    .lookup_tag (lookup_tag),
    .tags       (tags),
    .valids     (valids),
    .ages       (ages),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stores, written from the held refill line address
  ////////////////////////////////////////////////////////////////////////////

  icache_tag_store u_tag_store (
    .clk       (clk),
    .rst       (rst),
    .rd_index  (rd_index),
    .wr_en     (tag_wr_en),
    .wr_index  (mem_addr[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB]),
    .wr_way    (wr_way),
    .wr_tag    (mem_addr[`ICACHE_TAG_MSB:`ICACHE_TAG_LSB]),
    .touch     (touch),
    .touch_way (touch_way),
    .tags      (tags),
    .valids    (valids),
    .ages      (ages)
  );

  icache_data_store u_data_store (
    .clk       (clk),
    .rd_index  (rd_index),
    .rd_offset (rd_offset),
    .sel_way   (sel_way),
    .wr_en     (data_wr_en),
    .wr_way    (wr_way),
    .wr_index  (mem_addr[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB]),
    .wr_offset (data_wr_offset),
    .wr_data   (data_wr_data),
    .rd_word   (inst)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////////////////////////////////////////

  icache_refill u_refill (
    .clk            (clk),
    .rst            (rst),
    .start          (refill_start),
    .line_addr      (refill_addr),
    .way            (refill_way),
    .mem_addr_ok    (mem_addr_ok),
    .mem_data_ok    (mem_data_ok),
    .mem_data       (mem_data),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .data_wr_en     (data_wr_en),
    .data_wr_offset (data_wr_offset),
    .data_wr_data   (data_wr_data),
    .tag_wr_en      (tag_wr_en),
    .wr_way         (wr_way),
    .done           (done)
  );

endmodule

// ==== icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker (
  input  logic  clk,
  input  logic  rst,
  input  logic  ok,
  input  logic  mem_req,
  input  logic  mem_addr_ok
);

  int unsigned fail_count;

  initial
  begin
    fail_count = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Top-level handshake rules
  ////////////////////////////////////////////////////////////////////////////

  // CPU answer and memory request are exclusive
  a_ok_mem_excl: assert property (@(posedge clk) disable iff (rst) !(ok && mem_req))
  else
  begin
    fail_count++;
    $error("ok and mem_req high in the same cycle");
  end

  a_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_addr_ok |=> mem_req)
  else
  begin
    fail_count++;
    $error("mem_req dropped before mem_addr_ok");
  end

  // Request goes away right after address acceptance
  a_req_drop: assert property (@(posedge clk) disable iff (rst)
    mem_req && mem_addr_ok |=> !mem_req)
  else
  begin
    fail_count++;
    $error("mem_req still high after mem_addr_ok");
  end

  a_ok_pulse: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
  else
  begin
    fail_count++;
    $error("ok high for two cycles");
  end

endmodule

// ==== icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tb;

  localparam int HALF_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int WAIT_LIMIT  = 50;
  localparam int RAND_FETCHES = 80;

  logic               clk;
  logic               rst;
  logic               req;
  icache_pkg::addr_t  fetch_addr;
  icache_pkg::word_t  inst;
  logic               ok;
  logic               mem_req;
  icache_pkg::addr_t  mem_addr;
  logic               mem_addr_ok;
  logic               mem_data_ok;
  icache_pkg::word_t  mem_data;

  int checks   = 0;
  int errors   = 0;
  int timeouts = 0;

  logic [31:0] lfsr_state = 32'h4e1d;

  // Reference model state
  icache_pkg::tag_t  m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  logic              m_valid [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::age_t  m_age   [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::tag_t  last_evicted;

  icache_pkg::tag_t  pool    [6];
  icache_pkg::tag_t  dir_tag [5];

  icache_top u_icache_top (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .fetch_addr  (fetch_addr),
    .inst        (inst),
    .ok          (ok),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok),
    .mem_data    (mem_data)
  );

  bind icache_top icache_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .ok          (ok),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok)
  );

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Memory contents scrambled from the word address
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
    icache_pkg::addr_t a;
    a = {addr[31:2], 2'b00};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic icache_pkg::addr_t make_addr(input icache_pkg::tag_t t,
                                                  input icache_pkg::index_t s,
                                                  input icache_pkg::offset_t o,
                                                  input logic [1:0] low);
    return {t, s, o, low};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cache model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void model_touch(input icache_pkg::index_t s, input int way);
    icache_pkg::age_t ref_age;
    ref_age = m_age[way][s];
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (w != way && m_age[w][s] <= ref_age)
        m_age[w][s] = m_age[w][s] + 2'd1;
    m_age[way][s] = '0;
  endfunction

  function automatic int model_victim(input icache_pkg::index_t s);
    int v;
    logic found;
    found = 1'b0;
    v = 0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!found && !m_valid[w][s])
      begin
        found = 1'b1;
        v = w;
      end
    end
    // All valid so the strictly oldest wins and ties keep the lower way
    if (!found)
      for (int w = 1; w < `ICACHE_WAYS; w++)
        if (m_age[w][s] > m_age[v][s])
          v = w;
    return v;
  endfunction

  // Returns the predicted hit and updates the model as the access would
  function automatic logic model_access(input icache_pkg::addr_t addr);
    icache_pkg::tag_t   t;
    icache_pkg::index_t s;
    int                 way;
    logic               hit;
    t = addr[`ICACHE_TAG_MSB:`ICACHE_TAG_LSB];
    s = addr[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!hit && m_valid[w][s] && m_tag[w][s] == t)
      begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit)
    begin
      way = model_victim(s);
      last_evicted = m_tag[way][s];
      m_tag[way][s] = t;
      m_valid[way][s] = 1'b1;
    end
    model_touch(s, way);
    return hit;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder and CPU fetch
  ////////////////////////////////////////////////////////////////////////////

  task automatic serve_refill(input icache_pkg::addr_t base);
    logic [31:0] r;
    check_eq("mem_addr", mem_addr, base);
    r = rand_bits(2);
    repeat (r)
    begin
      next_cycle();
      check_eq("mem_req", 32'(mem_req), 32'd1);
    end
    mem_addr_ok = 1'b1;
    next_cycle();
    mem_addr_ok = 1'b0;
    check_eq("mem_req", 32'(mem_req), 32'd0);
    for (int b = 0; b < `ICACHE_LINE_WORDS; b++)
    begin
      r = rand_bits(2);
      repeat (r)
        next_cycle();
      mem_data_ok = 1'b1;
      mem_data = mem_word(base + 32'(b * 4));
      next_cycle();
      mem_data_ok = 1'b0;
      mem_data = '0;
      check_eq("ok", 32'(ok), 32'd0);
      check_eq("mem_req", 32'(mem_req), 32'd0);
    end
  endtask

  task automatic do_fetch(input icache_pkg::addr_t addr, output logic was_hit);
    logic              exp_hit;
    icache_pkg::addr_t base;
    int                n;
    was_hit = 1'b0;
    if (timeouts != 0)
      return;
    exp_hit = model_access(addr);
    base = {addr[31:6], 6'b0};
    next_cycle();
    req = 1'b1;
    fetch_addr = addr;
    next_cycle();
    was_hit = ok;
    check_eq("ok", 32'(ok), 32'(exp_hit));
    if (ok === 1'b1)
    begin
      check_eq("mem_req", 32'(mem_req), 32'd0);
      check_eq("inst", inst, mem_word(addr));
    end
    else
    begin
      n = 0;
      while (mem_req !== 1'b1 && n < WAIT_LIMIT)
      begin
        check_eq("ok", 32'(ok), 32'd0);
        next_cycle();
        n++;
      end
      if (mem_req !== 1'b1)
      begin
        timeouts++;
        $display("Timeout while waiting for the memory request of a miss");
        req = 1'b0;
        return;
      end
      serve_refill(base);
      n = 0;
      while (ok !== 1'b1 && n < WAIT_LIMIT)
      begin
        check_eq("mem_req", 32'(mem_req), 32'd0);
        next_cycle();
        n++;
      end
      if (ok !== 1'b1)
      begin
        timeouts++;
        $display("Timeout while waiting for ok after a refill");
        req = 1'b0;
        return;
      end
      check_eq("inst", inst, mem_word(addr));
    end
    req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic                h;
    logic [31:0]         r;
    icache_pkg::index_t  s;
    icache_pkg::offset_t o;
    logic [1:0]          lo;
    icache_pkg::tag_t    evicted;
    rst = 1'b1;
    req = 1'b0;
    fetch_addr = '0;
    mem_addr_ok = 1'b0;
    mem_data_ok = 1'b0;
    mem_data = '0;
    last_evicted = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      for (int i = 0; i < `ICACHE_SETS; i++)
      begin
        m_tag[w][i] = '0;
        m_valid[w][i] = 1'b0;
        m_age[w][i] = '0;
      end
    pool[0] = 22'h00_100;
    pool[1] = 22'h01_235;
    pool[2] = 22'h02_46a;
    pool[3] = 22'h13_69f;
    pool[4] = 22'h24_8d4;
    pool[5] = 22'h3f_ff0;
    dir_tag[0] = pool[0];
    dir_tag[1] = 22'h2a_001;
    dir_tag[2] = 22'h2a_102;
    dir_tag[3] = 22'h2a_203;
    dir_tag[4] = 22'h2a_304;

    repeat (8)
    begin
      next_cycle();
      check_eq("ok", 32'(ok), 32'd0);
      check_eq("mem_req", 32'(mem_req), 32'd0);
    end
    rst = 1'b0;
    repeat (4)
    begin
      next_cycle();
      check_eq("ok", 32'(ok), 32'd0);
      check_eq("mem_req", 32'(mem_req), 32'd0);
    end

    // First touch of each set
    for (int i = 0; i < `ICACHE_SETS; i++)
    begin
      r = rand_bits(4);
      do_fetch(make_addr(pool[0], 4'(i), r[3:0], 2'd0), h);
      check_eq("hit", 32'(h), 32'd0);
    end

    // Set 5 fill order leaves dir_tag[1] as the oldest line
    do_fetch(make_addr(dir_tag[1], 4'd5, 4'd1, 2'd0), h);
    do_fetch(make_addr(dir_tag[2], 4'd5, 4'd2, 2'd1), h);
    do_fetch(make_addr(dir_tag[3], 4'd5, 4'd3, 2'd2), h);
    do_fetch(make_addr(dir_tag[0], 4'd5, 4'd4, 2'd3), h);
    do_fetch(make_addr(dir_tag[4], 4'd5, 4'd5, 2'd0), h);
    evicted = last_evicted;
    for (int k = 2; k <= 4; k++)
    begin
      do_fetch(make_addr(dir_tag[k], 4'd5, 4'(k + 8), 2'd0), h);
      check_eq("hit", 32'(h), 32'd1);
    end
    do_fetch(make_addr(dir_tag[0], 4'd5, 4'd15, 2'd0), h);
    check_eq("hit", 32'(h), 32'd1);
    do_fetch(make_addr(evicted, 4'd5, 4'd7, 2'd0), h);
    check_eq("hit", 32'(h), 32'd0);

    // Random fetches over sets 0 to 3 with six competing tags
    for (int i = 0; i < RAND_FETCHES; i++)
    begin
      r = rand_bits(2);
      s = r[3:0];
      r = rand_bits(3);
      if (r > 32'd5)
        r = r - 32'd6;
      o = icache_pkg::offset_t'(rand_bits(4));
      lo = 2'(rand_bits(2));
      do_fetch(make_addr(pool[r], s, o, lo), h);
    end

    repeat (4)
      next_cycle();
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, u_icache_top.u_checker.fail_count);
    if (errors == 0 && timeouts == 0 && u_icache_top.u_checker.fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
icache_pkg.sv
icache_tag_store.sv
icache_hit_select.sv
icache_data_store.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_checker.sv
icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module icache_tb -f files.f -o icache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/icache_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
